/* common/video_pkg.sv */
package video_pkg;

	////////////////////////////////////////////////////////////////////////////
	// raster and dot types
	////////////////////////////////////////////////////////////////////////////

	// raster counters
	typedef logic [8:0] hpos_t;
	typedef logic [8:0] vpos_t;

	// colour index of one pixel
	typedef logic [3:0] dot_t;

	// index 0 shows through to the back colour
	localparam dot_t DOT_CLEAR = 4'd0;

	// one word of the dot stream, as held in the FIFO
	typedef struct packed {
		logic line_start;
		logic frame_start;
		dot_t dot;
	} dot_word_t;

	// 4 bits per gun
	typedef struct packed {
		logic [3:0] red;
		logic [3:0] green;
		logic [3:0] blue;
	} rgb_t;

endpackage

/* common/host_pkg.sv */
package host_pkg;

	// host bus widths
	localparam int HOST_ADDR_W = 8;
	localparam int HOST_DATA_W = 12;

	// write target select
	typedef enum logic [1:0] {
		tile_map,
		palette,
		scroll,
		back_color
	} host_target_e;

endpackage

/* common/dot_if.sv */
`timescale 1ns/1ps

interface dot_if (
	input logic clk,
	input logic rst_n
);
	import video_pkg::*;

	// four-phase handshake
	logic req;
	logic ack;
	// held stable while req is high
	dot_word_t word;

	// tile layer side
	modport producer (input clk, input rst_n, input ack, output req, output word);

	// FIFO side
	modport buffer (input clk, input rst_n, input req, input word, output ack);

endinterface

/* design/timing_gen.sv */
`timescale 1ns/1ps

module timing_gen #(
	parameter int H_ACTIVE = 32,
	parameter int H_TOTAL = 40,
	parameter int V_ACTIVE = 16,
	parameter int V_TOTAL = 20,
	parameter int CLK_DIV = 8
) (
	input logic clk,
	input logic rst_n,
	output logic pix_ce,
	output logic frame_start,
	output video_pkg::hpos_t hpos,
	output video_pkg::vpos_t vpos,
	output logic hsync_n,
	output logic vsync_n,
	output logic hblank_n,
	output logic vblank_n
);
	import video_pkg::*;

	localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
	localparam hpos_t H_LAST = hpos_t'(H_TOTAL - 1);
	localparam vpos_t V_LAST = vpos_t'(V_TOTAL - 1);
	// sync windows sit a little way into blanking
	localparam hpos_t HS_FIRST = hpos_t'(H_ACTIVE + 2);
	localparam hpos_t HS_LAST = hpos_t'(H_ACTIVE + 5);
	localparam vpos_t VS_LINE = vpos_t'(V_ACTIVE + 1);

	logic [DIV_W-1:0] div_cnt;

	// master clock down to the pixel rate
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			div_cnt <= '0;
		end else if (pix_ce) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// last clock of each pixel period
	assign pix_ce = (div_cnt == DIV_W'(CLK_DIV - 1));

	// raster walk, one step per pixel
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			hpos <= '0;
			vpos <= '0;
		end else if (pix_ce) begin
			if (hpos == H_LAST) begin
				hpos <= '0;
				vpos <= (vpos == V_LAST) ? '0 : vpos + 1'b1;
			end else begin
				hpos <= hpos + 1'b1;
			end
		end
	end

	// blanking and sync straight from the counters
	assign hblank_n = (hpos < hpos_t'(H_ACTIVE));
	assign vblank_n = (vpos < vpos_t'(V_ACTIVE));
	assign hsync_n = !((hpos >= HS_FIRST) && (hpos <= HS_LAST));
	assign vsync_n = (vpos != VS_LINE);

	// first pixel of the first blank line
	assign frame_start = pix_ce && (hpos == '0) && (vpos == vpos_t'(V_ACTIVE));

endmodule

/* tilegen/tile_fetch.sv */
`timescale 1ns/1ps

module tile_fetch #(
	parameter int H_ACTIVE = 32,
	parameter int V_ACTIVE = 16
) (
	input logic clk,
	input logic rst_n,
	input logic frame_start,
	input logic map_we,
	input logic scroll_we,
	input logic [host_pkg::HOST_ADDR_W-1:0] host_addr,
	input logic [host_pkg::HOST_DATA_W-1:0] host_data,
	dot_if.producer dots
);
	import video_pkg::*;

	// one map entry per 8x8 tile
	localparam int TILES_X = H_ACTIVE / 8;
	localparam int TILES_Y = V_ACTIVE / 8;
	localparam int MAP_SIZE = TILES_X * TILES_Y;
	localparam int MAP_AW = (MAP_SIZE > 1) ? $clog2(MAP_SIZE) : 1;

	typedef enum logic [1:0] {
		idle,
		present,
		wait_ack,
		wait_release
	} fetch_state_e;

	fetch_state_e state;
	dot_t map_ram [MAP_SIZE];
	hpos_t scroll_x;
	vpos_t scroll_y;
	hpos_t cur_scroll_x;
	vpos_t cur_scroll_y;
	hpos_t walk_x;
	vpos_t walk_y;
	logic [9:0] sum_x;
	logic [9:0] sum_y;
	hpos_t wrap_x;
	vpos_t wrap_y;
	logic [MAP_AW-1:0] map_idx;
	dot_word_t next_word;
	logic more;
	logic send;

	////////////////////////////////////////////////////////////////////////////
	// host registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (map_we && (host_addr < MAP_SIZE)) begin
			map_ram[host_addr[MAP_AW-1:0]] <= host_data[3:0];
		end
	end

	// addr bit 0 picks y over x
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			scroll_x <= '0;
			scroll_y <= '0;
		end else if (scroll_we) begin
			if (host_addr[0]) begin
				scroll_y <= host_data[8:0];
			end else begin
				scroll_x <= host_data[8:0];
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// tile lookup for the current walk position
	////////////////////////////////////////////////////////////////////////////

	// scrolled position wraps inside the active area
	assign sum_x = {1'b0, walk_x} + {1'b0, cur_scroll_x};
	assign sum_y = {1'b0, walk_y} + {1'b0, cur_scroll_y};
	assign wrap_x = hpos_t'(sum_x % H_ACTIVE);
	assign wrap_y = vpos_t'(sum_y % V_ACTIVE);
	assign map_idx = MAP_AW'((wrap_y / 8) * TILES_X + (wrap_x / 8));

	always_comb begin
		next_word.line_start = (walk_x == '0);
		next_word.frame_start = (walk_x == '0) && (walk_y == '0);
		next_word.dot = map_ram[map_idx];
	end

	////////////////////////////////////////////////////////////////////////////
	// dot handshake FSM
	////////////////////////////////////////////////////////////////////////////

	// walk_y runs one past the last line once the frame is out
	assign more = (walk_y != vpos_t'(V_ACTIVE));
	// next dot goes out only with ack low
	assign send = !dots.ack && ((state == present) || ((state == wait_release) && more));

	// word only changes while req is low
	always_ff @(posedge clk) begin
		if (send) begin
			dots.word <= next_word;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= idle;
			dots.req <= 1'b0;
			walk_x <= '0;
			walk_y <= '0;
			cur_scroll_x <= '0;
			cur_scroll_y <= '0;
		end else if (frame_start) begin
			// restart at the top left with fresh scroll
			state <= present;
			dots.req <= 1'b0;
			walk_x <= '0;
			walk_y <= '0;
			cur_scroll_x <= scroll_x;
			cur_scroll_y <= scroll_y;
		end else begin
			case (state)
				present: begin
					if (send) begin
						dots.req <= 1'b1;
						state <= wait_ack;
					end
				end
				wait_ack: begin
					if (dots.ack) begin
						dots.req <= 1'b0;
						state <= wait_release;
						// step the walk while the FIFO drops ack
						if (walk_x == hpos_t'(H_ACTIVE - 1)) begin
							walk_x <= '0;
							walk_y <= walk_y + 1'b1;
						end else begin
							walk_x <= walk_x + 1'b1;
						end
					end
				end
				wait_release: begin
					if (send) begin
						dots.req <= 1'b1;
						state <= wait_ack;
					end else if (!dots.ack) begin
						// whole frame sent
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

endmodule

/* design/dot_fifo.sv */
`timescale 1ns/1ps

module dot_fifo #(
	parameter int FIFO_DEPTH = 8
) (
	input logic clk,
	input logic rst_n,
	input logic flush,
	dot_if.buffer wr,
	input logic pop,
	output logic empty,
	output video_pkg::dot_word_t rd_word
);
	import video_pkg::*;

	localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

	dot_word_t mem [FIFO_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0] count;
	logic full;
	logic push;
	logic do_pop;

	// wrap at FIFO_DEPTH, which need not be a power of two
	function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
		logic [AW-1:0] nxt;
		if (ptr == AW'(FIFO_DEPTH - 1)) begin
			nxt = '0;
		end else begin
			nxt = ptr + 1'b1;
		end
		return nxt;
	endfunction

	assign full = (count == (AW + 1)'(FIFO_DEPTH));
	assign empty = (count == '0);
	// capture once per req, and hold off when full
	assign push = wr.req && !wr.ack && !full;
	assign do_pop = pop && !empty;
	assign rd_word = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= wr.word;
		end
	end

	// pointers, fill level and ack
	always_ff @(posedge clk) begin
		if (!rst_n || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			wr.ack <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// ack falls only after req has
			if (push) begin
				wr.ack <= 1'b1;
			end else if (!wr.req) begin
				wr.ack <= 1'b0;
			end
		end
	end

endmodule

/* videogen/palette_out.sv */
`timescale 1ns/1ps

module palette_out (
	input logic clk,
	input logic rst_n,
	input logic pix_ce,
	input logic hsync_n_in,
	input logic vsync_n_in,
	input logic hblank_n_in,
	input logic vblank_n_in,
	input logic pal_we,
	input logic back_we,
	input logic [host_pkg::HOST_ADDR_W-1:0] host_addr,
	input logic [host_pkg::HOST_DATA_W-1:0] host_data,
	input logic empty,
	input video_pkg::dot_word_t rd_word,
	output logic pop,
	output video_pkg::rgb_t rgb,
	output logic hsync_n,
	output logic vsync_n,
	output logic hblank_n,
	output logic vblank_n,
	output logic ce_out
);
	import video_pkg::*;

	rgb_t pal_ram [16];
	dot_t back_color;
	logic active;
	dot_t pix_index;

	////////////////////////////////////////////////////////////////////////////
	// host side
	////////////////////////////////////////////////////////////////////////////

	// palette entry is one 12-bit word
	always_ff @(posedge clk) begin
		if (pal_we && (host_addr[7:4] == 4'd0)) begin
			pal_ram[host_addr[3:0]] <= host_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			back_color <= DOT_CLEAR;
		end else if (back_we) begin
			back_color <= host_data[3:0];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// dot to colour
	////////////////////////////////////////////////////////////////////////////

	assign active = hblank_n_in && vblank_n_in;
	// one dot per active pixel
	assign pop = pix_ce && active && !empty;
	// clear dots and underruns both show the back colour
	assign pix_index = (empty || (rd_word.dot == DOT_CLEAR)) ? back_color : rd_word.dot;

	// rgb and timing move together on pix_ce
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rgb <= '0;
			hsync_n <= 1'b1;
			vsync_n <= 1'b1;
			hblank_n <= 1'b1;
			vblank_n <= 1'b1;
			ce_out <= 1'b0;
		end else begin
			// marks the first clock of each new pixel
			ce_out <= pix_ce;
			if (pix_ce) begin
				rgb <= active ? pal_ram[pix_index] : '0;
				hsync_n <= hsync_n_in;
				vsync_n <= vsync_n_in;
				hblank_n <= hblank_n_in;
				vblank_n <= vblank_n_in;
			end
		end
	end

endmodule

/* design/video_top.sv */
`timescale 1ns/1ps

module video_top #(
	parameter int H_ACTIVE = 32,
	parameter int H_TOTAL = 40,
	parameter int V_ACTIVE = 16,
	parameter int V_TOTAL = 20,
	parameter int CLK_DIV = 8,
	parameter int FIFO_DEPTH = 8
) (
	input logic clk,
	input logic rst_n,
	input logic host_we,
	input host_pkg::host_target_e host_target,
	input logic [host_pkg::HOST_ADDR_W-1:0] host_addr,
	input logic [host_pkg::HOST_DATA_W-1:0] host_data,
	output logic vid_ce,
	output logic vid_hsync_n,
	output logic vid_vsync_n,
	output logic vid_hblank_n,
	output logic vid_vblank_n,
	output logic [3:0] vid_red,
	output logic [3:0] vid_green,
	output logic [3:0] vid_blue
);
	import host_pkg::*;
	import video_pkg::*;

	logic pix_ce;
	logic frame_start;
	logic hsync_n;
	logic vsync_n;
	logic hblank_n;
	logic vblank_n;
	logic map_we;
	logic scroll_we;
	logic pal_we;
	logic back_we;
	logic fifo_empty;
	logic fifo_pop;
	dot_word_t fifo_word;
	rgb_t rgb;

	////////////////////////////////////////////////////////////////////////////
	// host write decode
	////////////////////////////////////////////////////////////////////////////

	// strobes land in the registers on the next edge
	assign map_we = host_we && (host_target == tile_map);
	assign scroll_we = host_we && (host_target == scroll);
	assign pal_we = host_we && (host_target == palette);
	assign back_we = host_we && (host_target == back_color);

	////////////////////////////////////////////////////////////////////////////
	// video chain
	////////////////////////////////////////////////////////////////////////////

	dot_if i_dots (.clk(clk), .rst_n(rst_n));

	// raster position left open for probing
	timing_gen #(
		.H_ACTIVE(H_ACTIVE),
		.H_TOTAL(H_TOTAL),
		.V_ACTIVE(V_ACTIVE),
		.V_TOTAL(V_TOTAL),
		.CLK_DIV(CLK_DIV)
	) i_timing_gen (
		.clk(clk),
		.rst_n(rst_n),
		.pix_ce(pix_ce),
		.frame_start(frame_start),
		.hpos(),
		.vpos(),
		.hsync_n(hsync_n),
		.vsync_n(vsync_n),
		.hblank_n(hblank_n),
		.vblank_n(vblank_n)
	);

	tile_fetch #(
		.H_ACTIVE(H_ACTIVE),
		.V_ACTIVE(V_ACTIVE)
	) i_tile_fetch (
		.clk(clk),
		.rst_n(rst_n),
		.frame_start(frame_start),
		.map_we(map_we),
		.scroll_we(scroll_we),
		.host_addr(host_addr),
		.host_data(host_data),
		.dots(i_dots.producer)
	);

	// emptied at frame_start while the producer restarts
	dot_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) i_dot_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.flush(frame_start),
		.wr(i_dots.buffer),
		.pop(fifo_pop),
		.empty(fifo_empty),
		.rd_word(fifo_word)
	);

	palette_out i_palette_out (
		.clk(clk),
		.rst_n(rst_n),
		.pix_ce(pix_ce),
		.hsync_n_in(hsync_n),
		.vsync_n_in(vsync_n),
		.hblank_n_in(hblank_n),
		.vblank_n_in(vblank_n),
		.pal_we(pal_we),
		.back_we(back_we),
		.host_addr(host_addr),
		.host_data(host_data),
		.empty(fifo_empty),
		.rd_word(fifo_word),
		.pop(fifo_pop),
		.rgb(rgb),
		.hsync_n(vid_hsync_n),
		.vsync_n(vid_vsync_n),
		.hblank_n(vid_hblank_n),
		.vblank_n(vid_vblank_n),
		.ce_out(vid_ce)
	);

	// split the colour word onto the guns
	assign vid_red = rgb.red;
	assign vid_green = rgb.green;
	assign vid_blue = rgb.blue;

endmodule

/* testbench/tb_video_top.sv */
`timescale 1ns/1ps

module tb_video_top;
	import host_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// raster setup, handed to the DUT as is
	////////////////////////////////////////////////////////////////////////////

	localparam int H_ACTIVE = 32;
	localparam int H_TOTAL = 40;
	localparam int V_ACTIVE = 16;
	localparam int V_TOTAL = 20;
	localparam int CLK_DIV = 8;
	localparam int FIFO_DEPTH = 8;
	localparam int RESET_CYCLES = 10;
	// frames 0 to 3 get checked, run stops as frame 4 starts
	localparam int NUM_FRAMES = 4;
	localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL * CLK_DIV;
	// ten percent margin on top
	localparam int TIMEOUT_CYCLES = NUM_FRAMES * FRAME_CYCLES * 11 / 10;
	// kind, frame, a, b, data
	localparam int REC_WORDS = 5;
	localparam int MAX_RECS = 64;

	logic clk;
	logic rst_n;
	logic host_we;
	host_target_e host_target;
	logic [HOST_ADDR_W-1:0] host_addr;
	logic [HOST_DATA_W-1:0] host_data;
	logic vid_ce;
	logic vid_hsync_n;
	logic vid_vsync_n;
	logic vid_hblank_n;
	logic vid_vblank_n;
	logic [3:0] vid_red;
	logic [3:0] vid_green;
	logic [3:0] vid_blue;

	// raw words straight from the data file
	logic [11:0] tdata [REC_WORDS*MAX_RECS];
	int wr_frame [$];
	logic [1:0] wr_target [$];
	logic [7:0] wr_addr [$];
	logic [11:0] wr_data [$];
	int exp_frame [$];
	int exp_x [$];
	int exp_y [$];
	logic [11:0] exp_rgb [$];
	bit exp_seen [$];

	int cycle_cnt = 0;
	// -1 until the first active pixel after reset
	int frame_no = -1;
	int pix_x = 0;
	int line_cnt = 0;
	int hs_cnt = 0;
	int vs_cnt = 0;
	logic prev_hsync_n = 1'b1;
	logic prev_vsync_n = 1'b1;
	logic prev_vblank_n = 1'b0;
	logic prev_active = 1'b0;
	int pixel_errors = 0;
	int timing_errors = 0;
	int reset_errors = 0;
	int other_errors = 0;

	video_top #(
		.H_ACTIVE(H_ACTIVE),
		.H_TOTAL(H_TOTAL),
		.V_ACTIVE(V_ACTIVE),
		.V_TOTAL(V_TOTAL),
		.CLK_DIV(CLK_DIV),
		.FIFO_DEPTH(FIFO_DEPTH)
	) i_dut (
		.clk(clk),
		.rst_n(rst_n),
		.host_we(host_we),
		.host_target(host_target),
		.host_addr(host_addr),
		.host_data(host_data),
		.vid_ce(vid_ce),
		.vid_hsync_n(vid_hsync_n),
		.vid_vsync_n(vid_vsync_n),
		.vid_hblank_n(vid_hblank_n),
		.vid_vblank_n(vid_vblank_n),
		.vid_red(vid_red),
		.vid_green(vid_green),
		.vid_blue(vid_blue)
	);

	// 4 ns clock
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////

	// split the file into write and expected records
	task automatic load_records();
		int r;
		int base;
		bit done;
		r = 0;
		done = 1'b0;
		$readmemh("testbench/video_testdata.txt", tdata);
		while (!done && (r < MAX_RECS)) begin
			base = r * REC_WORDS;
			case (tdata[base])
				12'h001: begin
					wr_frame.push_back(int'(tdata[base+1]));
					wr_target.push_back(tdata[base+2][1:0]);
					wr_addr.push_back(tdata[base+3][7:0]);
					wr_data.push_back(tdata[base+4]);
				end
				12'h002: begin
					exp_frame.push_back(int'(tdata[base+1]));
					exp_x.push_back(int'(tdata[base+2]));
					exp_y.push_back(int'(tdata[base+3]));
					exp_rgb.push_back(tdata[base+4]);
					exp_seen.push_back(1'b0);
				end
				// end marker or unfilled words
				default: done = 1'b1;
			endcase
			r++;
		end
	endtask

	// one strobe, effective one clock later
	task automatic host_write(input logic [1:0] target, input logic [7:0] addr,
			input logic [11:0] data);
		@(posedge clk);
		host_we <= 1'b1;
		host_target <= host_target_e'(target);
		host_addr <= addr;
		host_data <= data;
		@(posedge clk);
		host_we <= 1'b0;
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		assert (actual == expected) else begin
			timing_errors++;
			$display("ERR %s expected %0d actual %0d", name, expected, actual);
		end
	endtask

	// look the pixel up among the expected records
	task automatic compare_pixel(input int frame, input int x, input int y,
			input logic [11:0] pix);
		int i;
		string name;
		for (i = 0; i < exp_frame.size(); i++) begin
			if ((exp_frame[i] == frame) && (exp_x[i] == x) && (exp_y[i] == y)) begin
				exp_seen[i] = 1'b1;
				name = $sformatf("pixel_f%0d_x%0d_y%0d", frame, x, y);
				assert (pix == exp_rgb[i]) else begin
					pixel_errors++;
					$display("ERR %s expected %03h actual %03h", name, exp_rgb[i], pix);
				end
			end
		end
	endtask

	task automatic check_unseen();
		int i;
		for (i = 0; i < exp_frame.size(); i++) begin
			assert (exp_seen[i]) else begin
				other_errors++;
				$display("expected pixel at frame %0d x %0d y %0d was never displayed",
					exp_frame[i], exp_x[i], exp_y[i]);
			end
		end
	endtask

	task automatic report_counts();
		$display("errors: pixel %0d timing %0d reset %0d other %0d",
			pixel_errors, timing_errors, reset_errors, other_errors);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// output monitors
	////////////////////////////////////////////////////////////////////////////

	// all outputs inactive and dark while in reset
	always @(negedge clk) begin
		if (!rst_n && (cycle_cnt >= 1)) begin
			assert (vid_hsync_n && vid_vsync_n && vid_hblank_n && vid_vblank_n && !vid_ce
					&& ({vid_red, vid_green, vid_blue} == 12'h000)) else begin
				reset_errors++;
				$display("ERR reset_state expected %b %03h actual %b %03h", 5'b11110, 12'h000,
					{vid_hsync_n, vid_vsync_n, vid_hblank_n, vid_vblank_n, vid_ce},
					{vid_red, vid_green, vid_blue});
			end
		end
	end

	// one sample per pixel, mid-cycle
	always @(negedge clk) begin
		logic active;
		logic [11:0] pix;
		if (rst_n && vid_ce) begin
			active = vid_hblank_n && vid_vblank_n;
			pix = {vid_red, vid_green, vid_blue};
			// frame boundary on the first active pixel
			if (!prev_vblank_n && vid_vblank_n) begin
				if (frame_no >= 0) begin
					check_count($sformatf("lines_f%0d", frame_no), V_ACTIVE, line_cnt);
					check_count($sformatf("hsync_f%0d", frame_no), V_TOTAL, hs_cnt);
					check_count($sformatf("vsync_f%0d", frame_no), 1, vs_cnt);
				end
				frame_no = frame_no + 1;
				line_cnt = 0;
				hs_cnt = 0;
				vs_cnt = 0;
				pix_x = 0;
			end
			if (prev_hsync_n && !vid_hsync_n) begin
				hs_cnt++;
			end
			if (prev_vsync_n && !vid_vsync_n) begin
				vs_cnt++;
			end
			if (active) begin
				compare_pixel(frame_no, pix_x, line_cnt, pix);
				pix_x++;
			end else if (prev_active) begin
				// active run just ended
				check_count($sformatf("width_f%0d_y%0d", frame_no, line_cnt), H_ACTIVE, pix_x);
				line_cnt++;
				pix_x = 0;
			end
			prev_hsync_n = vid_hsync_n;
			prev_vsync_n = vid_vsync_n;
			prev_vblank_n = vid_vblank_n;
			prev_active = active;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus and end of run
	////////////////////////////////////////////////////////////////////////////

	initial begin
		wait (cycle_cnt >= TIMEOUT_CYCLES);
		$display("timeout: frame %0d not reached within %0d clocks", NUM_FRAMES, TIMEOUT_CYCLES);
		report_counts();
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		int i;
		rst_n = 1'b0;
		host_we = 1'b0;
		host_target = tile_map;
		host_addr = '0;
		host_data = '0;
		load_records();
		assert ((wr_frame.size() > 0) && (exp_frame.size() > 0)) else begin
			other_errors++;
			$display("no host writes or expected pixels found in the data file");
		end
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		for (i = 0; i < wr_frame.size(); i++) begin
			// hold each write until its frame is on screen
			wait (frame_no >= wr_frame[i]);
			host_write(wr_target[i], wr_addr[i], wr_data[i]);
		end
		wait (frame_no >= NUM_FRAMES);
		check_unseen();
		report_counts();
		if ((pixel_errors + timing_errors + reset_errors + other_errors) == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* testbench/video_testdata.txt */
// kind frame a b data, all hex; kind 0 ends the list
// kind 1 host write: a target (0 map, 1 palette, 2 scroll, 3 back), b address
// kind 2 expected pixel: a x, b y, data rgb as red green blue nibbles
1 0 01 01 f00
1 0 01 02 0f0
1 0 01 03 00f
1 0 01 04 ff0
1 0 03 00 004
// tile map, top row then bottom row
1 0 00 00 001
1 0 00 01 002
1 0 00 02 000
1 0 00 03 003
1 0 00 04 003
1 0 00 05 000
1 0 00 06 001
1 0 00 07 002
// scroll (11,5) written early in frame 2
1 2 02 00 00b
1 2 02 01 005
// frame 1, zero scroll, index 0 tiles show the back colour
2 1 00 00 f00
2 1 09 02 0f0
2 1 11 05 ff0
2 1 1f 07 00f
2 1 03 08 00f
2 1 0c 0f ff0
2 1 14 09 f00
2 1 1b 0e 0f0
// frame 2 still unscrolled
2 2 09 02 0f0
2 2 14 09 f00
2 2 03 08 00f
// frame 3 scrolled, wrapping at the edges
2 3 00 00 0f0
2 3 05 00 ff0
2 3 15 02 f00
2 3 14 03 0f0
2 3 1a 06 00f
2 3 0d 0b 00f
2 3 1e 0f 0f0
0 0 00 00 000

/* compile.f */
common/video_pkg.sv
common/host_pkg.sv
common/dot_if.sv
design/timing_gen.sv
tilegen/tile_fetch.sv
design/dot_fifo.sv
videogen/palette_out.sv
design/video_top.sv
testbench/tb_video_top.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS ?= --binary --assert -Wno-fatal -j 0
TOP ?= tb_video_top
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	grep -qx "TEST OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
